// File: files.f
+incdir+test
hw/exec_isa_pkg.sv
hw/exec_pipe_pkg.sv
hw/exec_alu.sv
hw/exec_mul_datapath.sv
hw/exec_mul_counter.sv
hw/exec_sequencer.sv
hw/exec_result_mux.sv
hw/exec_stage_reg.sv
hw/exec_stage_top.sv
test/tb_exec_stage.sv

// File: hw/exec_alu.sv
// ------------------------------------------------
// Combinational ALU
// Result plus sum, less-than and equal outputs
// ------------------------------------------------
`timescale 1ns/10ps

module exec_alu (
    input  exec_isa_pkg::uop_u            i_uop,    // Micro-op
    input  exec_isa_pkg::fu_e             i_fu,     // Unit, for compare decode
    input  logic [exec_isa_pkg::XLEN-1:0] i_lhs,    // Left operand
    input  logic [exec_isa_pkg::XLEN-1:0] i_rhs,    // Right operand
    output logic [exec_isa_pkg::XLEN-1:0] o_result, // Selected op result
    output logic [exec_isa_pkg::XLEN-1:0] o_sum,    // Always lhs + rhs
    output logic                          o_lt,     // lhs < rhs
    output logic                          o_eq      // lhs == rhs
);

    logic                               cmp_unsigned;   // Unsigned compare select
    logic [exec_isa_pkg::XLEN:0]        lhs_ext;        // Sign or zero extended
    logic [exec_isa_pkg::XLEN:0]        rhs_ext;
    logic [exec_isa_pkg::XLEN-1:0]      diff;           // lhs - rhs
    logic [exec_isa_pkg::SHAMT_W-1:0]   shamt;          // Shift distance

    // SLTU, BLTU and BGEU compare unsigned
    assign cmp_unsigned =
        (i_fu == exec_isa_pkg::FU_ALU && i_uop.alu == exec_isa_pkg::ALU_SLTU) ||
        (i_fu == exec_isa_pkg::FU_CFU && (i_uop.cfu == exec_isa_pkg::CFU_BLTU ||
                                          i_uop.cfu == exec_isa_pkg::CFU_BGEU));

    // Extra top bit is the sign in signed mode, zero otherwise
    assign lhs_ext = {!cmp_unsigned && i_lhs[exec_isa_pkg::XLEN-1], i_lhs};
    assign rhs_ext = {!cmp_unsigned && i_rhs[exec_isa_pkg::XLEN-1], i_rhs};

    assign o_lt  = $signed(lhs_ext) < $signed(rhs_ext);
    assign o_eq  = i_lhs == i_rhs;
    assign o_sum = i_lhs + i_rhs;           // Also address and JALR target
    assign diff  = i_lhs - i_rhs;
    assign shamt = i_rhs[exec_isa_pkg::SHAMT_W-1:0];

    // ------------------------------------------------
    // Result select
    always_comb begin
        case (i_uop.alu)
            exec_isa_pkg::ALU_ADD:  o_result = o_sum;
            exec_isa_pkg::ALU_SUB:  o_result = diff;
            exec_isa_pkg::ALU_XOR:  o_result = i_lhs ^ i_rhs;
            exec_isa_pkg::ALU_OR:   o_result = i_lhs | i_rhs;
            exec_isa_pkg::ALU_AND:  o_result = i_lhs & i_rhs;
            exec_isa_pkg::ALU_SLL:  o_result = i_lhs << shamt;
            exec_isa_pkg::ALU_SRL:  o_result = i_lhs >> shamt;
            exec_isa_pkg::ALU_SRA:  o_result = $signed(i_lhs) >>> shamt; // Sign fill
            exec_isa_pkg::ALU_SLT,
            exec_isa_pkg::ALU_SLTU: o_result = {{(exec_isa_pkg::XLEN-1){1'b0}}, o_lt};
            default:                o_result = o_sum;
        endcase
    end

endmodule

// File: hw/exec_isa_pkg.sv
// ------------------------------------------------
// ISA level constants for the execute stage
// Functional unit and micro-op encodings
// Micro-op union, one word decoded per unit
// ------------------------------------------------

package exec_isa_pkg;

    localparam int XLEN      = 32;                      // Data word width
    localparam int MUL_STEPS = XLEN;                    // One multiplier bit per step
    localparam int MUL_CNT_W = $clog2(MUL_STEPS + 1);   // Step counter width
    localparam int SHAMT_W   = $clog2(XLEN);            // Shift amount width

    // One-hot unit select
    typedef enum logic [4:0] {
        FU_ALU = 5'b00001,
        FU_MUL = 5'b00010,
        FU_LSU = 5'b00100,
        FU_CFU = 5'b01000,
        FU_CSR = 5'b10000
    } fu_e;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_XOR  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_AND  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_SLT  = 5'd8,
        ALU_SLTU = 5'd9
    } alu_op_e;

    typedef enum logic [4:0] {
        MUL_MUL   = 5'd0,   // Low half of product
        MUL_MULHU = 5'd1    // High half, unsigned
    } mul_op_e;

    typedef struct packed {
        logic       load;   // Memory read
        logic       store;  // Memory write
        logic [2:0] size;   // Access size code
    } lsu_op_t;

    // Bits 4:3 group the ops: 00 conditional, 10 jump, 11 resolved branch
    typedef enum logic [4:0] {
        CFU_BEQ       = 5'b00001,
        CFU_BNE       = 5'b00010,
        CFU_BLT       = 5'b00011,
        CFU_BGE       = 5'b00100,
        CFU_BLTU      = 5'b00101,
        CFU_BGEU      = 5'b00110,
        CFU_JAL       = 5'b10001,
        CFU_JALR      = 5'b10010,
        CFU_TAKEN     = 5'b11001,
        CFU_NOT_TAKEN = 5'b11010
    } cfu_op_e;

    typedef union packed {
        alu_op_e alu;       // ALU view
        mul_op_e mul;       // Multiplier view
        lsu_op_t lsu;       // Load/store view
        cfu_op_e cfu;       // Control flow view
    } uop_u;

endpackage

// File: hw/exec_mul_counter.sv
// ------------------------------------------------
// Multiplier step counter with last-step flag
// ------------------------------------------------
`timescale 1ns/10ps

module exec_mul_counter (
    input  logic g_clk,
    input  logic g_resetn,
    input  logic i_start,   // Load full step count
    input  logic i_step,    // One step taken
    output logic o_last     // Current step is the final one
);

    logic [exec_isa_pkg::MUL_CNT_W-1:0] count;  // Steps remaining

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            count <= '0;
        end else if (i_start) begin
            count <= exec_isa_pkg::MUL_CNT_W'(exec_isa_pkg::MUL_STEPS);
        end else if (i_step && count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign o_last = count == exec_isa_pkg::MUL_CNT_W'(1);

endmodule

// File: hw/exec_mul_datapath.sv
// ------------------------------------------------
// Shift-add multiplier datapath
// One multiplier bit consumed per step
// ------------------------------------------------
`timescale 1ns/10ps

module exec_mul_datapath (
    input  logic                            g_clk,
    input  logic                            g_resetn,
    input  logic                            i_start,    // Load operands
    input  logic                            i_step,     // Add and shift once
    input  logic [exec_isa_pkg::XLEN-1:0]   i_rs1,      // Multiplicand
    input  logic [exec_isa_pkg::XLEN-1:0]   i_rs2,      // Multiplier
    output logic [2*exec_isa_pkg::XLEN-1:0] o_product   // Unsigned product
);

    logic [exec_isa_pkg::XLEN-1:0]   mcand;     // Held multiplicand
    logic [2*exec_isa_pkg::XLEN-1:0] prod;      // Accumulator over multiplier bits
    logic [exec_isa_pkg::XLEN-1:0]   addend;    // Multiplicand or zero
    logic [exec_isa_pkg::XLEN:0]     acc_sum;   // Upper half plus addend, with carry

    assign addend  = prod[0] ? mcand : '0;      // Current multiplier bit
    assign acc_sum = {1'b0, prod[2*exec_isa_pkg::XLEN-1:exec_isa_pkg::XLEN]} + {1'b0, addend};

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            prod <= '0;
        end else if (i_start) begin
            prod <= {{exec_isa_pkg::XLEN{1'b0}}, i_rs2};    // Clear acc, multiplier low
        end else if (i_step) begin
            prod <= {acc_sum, prod[exec_isa_pkg::XLEN-1:1]}; // Carry in at the top
        end
    end

    always_ff @(posedge g_clk) begin
        if (i_start) begin
            mcand <= i_rs1;
        end
    end

    assign o_product = prod;

endmodule

// File: hw/exec_pipe_pkg.sv
// ------------------------------------------------
// Pipeline payloads around the execute stage
// Stage 2 input and stage 3 output structs
// ------------------------------------------------

package exec_pipe_pkg;

    typedef struct packed {
        logic [4:0]                    rd;      // Destination register
        exec_isa_pkg::fu_e             fu;      // Functional unit
        exec_isa_pkg::uop_u            uop;     // Micro-op
        logic [exec_isa_pkg::XLEN-1:0] opr_a;   // Operand A, usually rs1
        logic [exec_isa_pkg::XLEN-1:0] opr_b;   // Operand B, rs2 or immediate
        logic [exec_isa_pkg::XLEN-1:0] opr_c;   // Operand C, store data or target
    } s2_payload_t;

    typedef struct packed {
        logic [4:0]                    rd;      // Destination register
        exec_isa_pkg::fu_e             fu;      // Functional unit
        exec_isa_pkg::uop_u            uop;     // Micro-op, branches resolved
        logic [exec_isa_pkg::XLEN-1:0] opr_a;   // Result or address
        logic [exec_isa_pkg::XLEN-1:0] opr_b;   // Store data, CSR data, high half
    } s3_payload_t;

endpackage

// File: hw/exec_result_mux.sv
// ------------------------------------------------
// Stage 3 payload assembly
// Unit decode, branch resolution, operand select
// ------------------------------------------------
`timescale 1ns/10ps

module exec_result_mux (
    input  exec_pipe_pkg::s2_payload_t      i_s2,           // Stage 2 instruction
    input  logic [exec_isa_pkg::XLEN-1:0]   i_alu_result,   // ALU result
    input  logic [exec_isa_pkg::XLEN-1:0]   i_alu_sum,      // Address / JALR sum
    input  logic                            i_lt,           // Compare less-than
    input  logic                            i_eq,           // Compare equal
    input  logic [2*exec_isa_pkg::XLEN-1:0] i_product,      // Multiplier output
    output exec_pipe_pkg::s3_payload_t      o_s3            // Stage 3 payload
);

    logic                          br_cond;     // Conditional branch op
    logic                          br_taken;    // Condition holds
    logic [exec_isa_pkg::XLEN-1:0] prod_hi;
    logic [exec_isa_pkg::XLEN-1:0] prod_lo;

    assign prod_hi = i_product[2*exec_isa_pkg::XLEN-1:exec_isa_pkg::XLEN];
    assign prod_lo = i_product[exec_isa_pkg::XLEN-1:0];

    // Condition table, lt already unsigned for BLTU/BGEU
    always_comb begin
        br_cond  = 1'b1;
        br_taken = 1'b0;
        case (i_s2.uop.cfu)
            exec_isa_pkg::CFU_BEQ:  br_taken = i_eq;
            exec_isa_pkg::CFU_BNE:  br_taken = !i_eq;
            exec_isa_pkg::CFU_BLT,
            exec_isa_pkg::CFU_BLTU: br_taken = i_lt;
            exec_isa_pkg::CFU_BGE,
            exec_isa_pkg::CFU_BGEU: br_taken = !i_lt;
            default:                br_cond  = 1'b0;    // Jumps keep their uop
        endcase
    end

    always_comb begin
        o_s3.rd    = i_s2.rd;
        o_s3.fu    = i_s2.fu;
        o_s3.uop   = i_s2.uop;
        o_s3.opr_a = '0;
        o_s3.opr_b = '0;
        case (i_s2.fu)
            exec_isa_pkg::FU_ALU: o_s3.opr_a = i_alu_result;
            exec_isa_pkg::FU_MUL: begin
                o_s3.opr_a = (i_s2.uop.mul == exec_isa_pkg::MUL_MULHU) ? prod_hi : prod_lo;
                o_s3.opr_b = prod_hi;                   // High half for both
            end
            exec_isa_pkg::FU_LSU: begin
                o_s3.opr_a = i_alu_sum;                 // Effective address
                o_s3.opr_b = i_s2.opr_c;                // Store data
            end
            exec_isa_pkg::FU_CFU: begin
                if (i_s2.uop.cfu == exec_isa_pkg::CFU_JALR) begin
                    o_s3.opr_a = {i_alu_sum[exec_isa_pkg::XLEN-1:1], 1'b0};
                end else begin
                    o_s3.opr_a = {i_s2.opr_c[exec_isa_pkg::XLEN-1:1], 1'b0};
                end
                if (br_cond) begin
                    o_s3.uop.cfu = br_taken ? exec_isa_pkg::CFU_TAKEN
                                            : exec_isa_pkg::CFU_NOT_TAKEN;
                end
            end
            exec_isa_pkg::FU_CSR: begin
                o_s3.opr_a = i_s2.opr_a;
                o_s3.opr_b = i_s2.opr_c;                // CSR write data
            end
            default: ;
        endcase
    end

endmodule

// File: hw/exec_sequencer.sv
// ------------------------------------------------
// Execute stage sequencer FSM
// Busy, multiplier start/step and register load
// ------------------------------------------------
`timescale 1ns/10ps

module exec_sequencer (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              i_flush,      // Abandon current work
    input  logic              i_s2_valid,   // Instruction presented
    input  exec_isa_pkg::fu_e i_fu,         // Its functional unit
    input  logic              i_mul_last,   // Final multiplier step
    input  logic              i_reg_busy,   // Output register held
    output logic              o_mul_start,  // Load multiplier
    output logic              o_mul_step,   // Step multiplier
    output logic              o_reg_load,   // Capture stage 3 payload
    output logic              o_s2_busy     // Stall upstream
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,    // Waiting for an instruction
        RUN  = 2'd1,    // Multiplier stepping
        DONE = 2'd2     // Product ready, waiting for register
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   is_mul;     // Presented op needs the multiplier

    assign is_mul = i_s2_valid && i_fu == exec_isa_pkg::FU_MUL;

    always_comb begin
        state_nxt   = state;
        o_mul_start = 1'b0;
        o_mul_step  = 1'b0;
        o_reg_load  = 1'b0;
        o_s2_busy   = 1'b1;
        case (state)
            IDLE: begin
                if (is_mul) begin
                    o_mul_start = 1'b1;     // Busy already high
                    state_nxt   = RUN;
                end else begin
                    o_s2_busy  = i_reg_busy;
                    o_reg_load = i_s2_valid && !i_reg_busy;
                end
            end
            RUN: begin
                o_mul_step = 1'b1;
                if (i_mul_last) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                o_s2_busy  = i_reg_busy;
                o_reg_load = i_s2_valid && !i_reg_busy;
                if (o_reg_load) begin
                    state_nxt = IDLE;       // Accepted on this edge
                end
            end
            default: state_nxt = IDLE;
        endcase
        if (i_flush) begin
            state_nxt = IDLE;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// File: hw/exec_stage_reg.sv
// ------------------------------------------------
// Stage 3 pipeline register
// Valid/busy handshake with flush
// ------------------------------------------------
`timescale 1ns/10ps

module exec_stage_reg (
    input  logic                       g_clk,
    input  logic                       g_resetn,
    input  logic                       i_flush,     // Drop held payload
    input  logic                       i_load,      // Capture new payload
    input  exec_pipe_pkg::s3_payload_t i_data,      // Payload in
    output logic                       o_busy,      // Held and not draining
    output logic                       o_valid,     // Payload offered
    output exec_pipe_pkg::s3_payload_t o_data,      // Payload out
    input  logic                       i_s3_busy    // Downstream stall
);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;
        end else if (i_load) begin
            o_valid <= 1'b1;
        end else if (!i_s3_busy) begin
            o_valid <= 1'b0;                // Payload left
        end
    end

    always_ff @(posedge g_clk) begin
        if (i_load) begin
            o_data <= i_data;
        end
    end

    assign o_busy = o_valid && i_s3_busy;

endmodule

// File: hw/exec_stage_top.sv
// ------------------------------------------------
// Execute stage top level
// ALU, multiplier, sequencer, mux and register
// ------------------------------------------------
`timescale 1ns/10ps

module exec_stage_top (
    input  logic                       g_clk,
    input  logic                       g_resetn,
    input  logic                       i_flush,
    input  logic                       i_s2_valid,
    input  exec_pipe_pkg::s2_payload_t i_s2,
    output logic                       o_s2_busy,
    output logic                       o_s3_valid,
    output exec_pipe_pkg::s3_payload_t o_s3,
    input  logic                       i_s3_busy
);

    logic [exec_isa_pkg::XLEN-1:0]   alu_result;
    logic [exec_isa_pkg::XLEN-1:0]   alu_sum;
    logic                            alu_lt;
    logic                            alu_eq;
    logic [2*exec_isa_pkg::XLEN-1:0] mul_product;
    logic                            mul_start;
    logic                            mul_step;
    logic                            mul_last;
    logic                            reg_load;
    logic                            reg_busy;
    exec_pipe_pkg::s3_payload_t      s3_next;   // Payload into register

    exec_alu alu_i (
        .i_uop    (i_s2.uop),
        .i_fu     (i_s2.fu),
        .i_lhs    (i_s2.opr_a),
        .i_rhs    (i_s2.opr_b),
        .o_result (alu_result),
        .o_sum    (alu_sum),
        .o_lt     (alu_lt),
        .o_eq     (alu_eq)
    );

    exec_mul_datapath mul_dp_i (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .i_start   (mul_start),
        .i_step    (mul_step),
        .i_rs1     (i_s2.opr_a),
        .i_rs2     (i_s2.opr_b),
        .o_product (mul_product)
    );

    exec_mul_counter mul_cnt_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_start  (mul_start),
        .i_step   (mul_step),
        .o_last   (mul_last)
    );

    exec_sequencer seq_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .i_flush     (i_flush),
        .i_s2_valid  (i_s2_valid),
        .i_fu        (i_s2.fu),
        .i_mul_last  (mul_last),
        .i_reg_busy  (reg_busy),
        .o_mul_start (mul_start),
        .o_mul_step  (mul_step),
        .o_reg_load  (reg_load),
        .o_s2_busy   (o_s2_busy)
    );

    exec_result_mux mux_i (
        .i_s2         (i_s2),
        .i_alu_result (alu_result),
        .i_alu_sum    (alu_sum),
        .i_lt         (alu_lt),
        .i_eq         (alu_eq),
        .i_product    (mul_product),
        .o_s3         (s3_next)
    );

    exec_stage_reg stage_reg_i (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .i_flush   (i_flush),
        .i_load    (reg_load),
        .i_data    (s3_next),
        .o_busy    (reg_busy),
        .o_valid   (o_s3_valid),
        .o_data    (o_s3),
        .i_s3_busy (i_s3_busy)
    );

endmodule

// File: test/tb_exec_vectors.svh
// ------------------------------------------------
// Stimulus and expected stage 3 results
// fu, uop, rd, opr_a, opr_b, opr_c, exp uop, exp opr_a, exp opr_b
// ------------------------------------------------
`ifndef TB_EXEC_VECTORS_SVH
`define TB_EXEC_VECTORS_SVH

localparam int NUM_VEC = 24;

localparam logic [4:0] F_ALU = exec_isa_pkg::FU_ALU;
localparam logic [4:0] F_MUL = exec_isa_pkg::FU_MUL;
localparam logic [4:0] F_LSU = exec_isa_pkg::FU_LSU;
localparam logic [4:0] F_CFU = exec_isa_pkg::FU_CFU;
localparam logic [4:0] F_CSR = exec_isa_pkg::FU_CSR;

typedef struct packed {
    logic [4:0]  fu;
    logic [4:0]  uop;
    logic [4:0]  rd;
    logic [31:0] opr_a;
    logic [31:0] opr_b;
    logic [31:0] opr_c;
    logic [4:0]  exp_uop;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
} vec_entry_t;

vec_entry_t vectors [NUM_VEC];
int         vec_fill = 0;

task automatic add_vector(input logic [4:0] fu, input logic [4:0] uop, input logic [4:0] rd,
                          input logic [31:0] a, input logic [31:0] b, input logic [31:0] c,
                          input logic [4:0] e_uop, input logic [31:0] e_a,
                          input logic [31:0] e_b);
    vectors[vec_fill] = '{fu, uop, rd, a, b, c, e_uop, e_a, e_b};
    vec_fill++;
endtask

task automatic fill_vectors();
    add_vector(F_ALU, 5'h00, 1, 32'h5, 32'h7, 32'h0, 5'h00, 32'hC, 32'h0);              // ADD
    add_vector(F_ALU, 5'h01, 2, 32'h5, 32'h7, 32'h0, 5'h01, 32'hFFFFFFFE, 32'h0);       // SUB
    add_vector(F_ALU, 5'h02, 3, 32'hF0F0F0F0, 32'h0FF00FF0, 32'h0, 5'h02, 32'hFF00FF00, 32'h0);
    add_vector(F_ALU, 5'h03, 4, 32'hF0F0F0F0, 32'h0FF00FF0, 32'h0, 5'h03, 32'hFFF0FFF0, 32'h0);
    add_vector(F_ALU, 5'h04, 5, 32'hF0F0F0F0, 32'h0FF00FF0, 32'h0, 5'h04, 32'h00F000F0, 32'h0);
    add_vector(F_ALU, 5'h05, 6, 32'h1, 32'h4, 32'h0, 5'h05, 32'h10, 32'h0);             // SLL
    add_vector(F_ALU, 5'h06, 7, 32'h80000000, 32'h4, 32'h0, 5'h06, 32'h08000000, 32'h0); // SRL
    add_vector(F_ALU, 5'h07, 8, 32'h80000000, 32'h4, 32'h0, 5'h07, 32'hF8000000, 32'h0); // SRA
    add_vector(F_ALU, 5'h08, 9, 32'hFFFFFFFF, 32'h1, 32'h0, 5'h08, 32'h1, 32'h0);       // SLT
    add_vector(F_ALU, 5'h09, 10, 32'hFFFFFFFF, 32'h1, 32'h0, 5'h09, 32'h0, 32'h0);      // SLTU
    add_vector(F_MUL, 5'h00, 11, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'h0, 5'h00, 32'h1, 32'hFFFFFFFE);
    add_vector(F_MUL, 5'h01, 12, 32'h00010000, 32'h00030000, 32'h0, 5'h01, 32'h3, 32'h3);
    add_vector(F_MUL, 5'h00, 13, 32'h1234, 32'h10, 32'h0, 5'h00, 32'h12340, 32'h0);
    add_vector(F_LSU, 5'h12, 14, 32'h1000, 32'h24, 32'h0, 5'h12, 32'h1024, 32'h0);      // Load
    add_vector(F_LSU, 5'h0A, 15, 32'h2000, 32'hFFFFFFFC, 32'hDEADBEEF, 5'h0A, 32'h1FFC,
               32'hDEADBEEF);                                                           // Store
    add_vector(F_CFU, 5'h01, 0, 32'h5, 32'h5, 32'h101, 5'h19, 32'h100, 32'h0);          // BEQ
    add_vector(F_CFU, 5'h02, 0, 32'h5, 32'h5, 32'h101, 5'h1A, 32'h100, 32'h0);          // BNE
    add_vector(F_CFU, 5'h03, 0, 32'hFFFFFFFF, 32'h1, 32'h101, 5'h19, 32'h100, 32'h0);   // BLT
    add_vector(F_CFU, 5'h04, 0, 32'hFFFFFFFF, 32'h1, 32'h101, 5'h1A, 32'h100, 32'h0);   // BGE
    add_vector(F_CFU, 5'h05, 0, 32'hFFFFFFFF, 32'h1, 32'h101, 5'h1A, 32'h100, 32'h0);   // BLTU
    add_vector(F_CFU, 5'h06, 0, 32'hFFFFFFFF, 32'h1, 32'h101, 5'h19, 32'h100, 32'h0);   // BGEU
    add_vector(F_CFU, 5'h11, 1, 32'h0, 32'h0, 32'h201, 5'h11, 32'h200, 32'h0);          // JAL
    add_vector(F_CFU, 5'h12, 1, 32'h3000, 32'h11, 32'h0, 5'h12, 32'h3010, 32'h0);       // JALR
    add_vector(F_CSR, 5'h00, 16, 32'hCAFEF00D, 32'h0, 32'h55, 5'h00, 32'hCAFEF00D, 32'h55);
endtask

`endif

// File: test/tb_exec_stage.sv
// ------------------------------------------------
// Testbench for the execute stage
// Table driven stimulus, random back-pressure
// In-order output checks and timeout
// ------------------------------------------------
`timescale 1ns/10ps

module tb_exec_stage;

    `include "tb_exec_vectors.svh"

    localparam int TIMEOUT = NUM_VEC * (exec_isa_pkg::MUL_STEPS + 8) + 20;

    logic                       g_clk;
    logic                       g_resetn;
    logic                       i_flush;
    logic                       i_s2_valid;
    exec_pipe_pkg::s2_payload_t i_s2;
    logic                       o_s2_busy;
    logic                       o_s3_valid;
    exec_pipe_pkg::s3_payload_t o_s3;
    logic                       i_s3_busy;
    int                         out_count = 0;      // Payloads taken downstream
    int                         cycle_count = 0;
    int                         busy_cycles;
    logic                       accepted;

    exec_stage_top dut_i (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .i_flush    (i_flush),
        .i_s2_valid (i_s2_valid),
        .i_s2       (i_s2),
        .o_s2_busy  (o_s2_busy),
        .o_s3_valid (o_s3_valid),
        .o_s3       (o_s3),
        .i_s3_busy  (i_s3_busy)
    );

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp, input int idx);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: entry %0d %s got %h expected %h",
                     $time, idx, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    // ------------------------------------------------
    // Random downstream stall, about one cycle in three
    initial begin
        void'($urandom(32'hacb605ab));
        i_s3_busy = 1'b0;
        forever begin
            @(posedge g_clk);
            i_s3_busy <= ($urandom % 3) == 0;
        end
    end

    // Outputs sampled mid-cycle, payload leaves on the next edge
    always @(negedge g_clk) begin
        if (g_resetn && o_s3_valid && !i_s3_busy) begin
            assert (out_count < NUM_VEC) else begin
                $display("Extra payload left the stage after the last table entry");
                $display("TEST FAILED");
                $fatal(1, "Duplicate output");
            end
            compare_field("rd", 32'(o_s3.rd), 32'(vectors[out_count].rd), out_count);
            compare_field("fu", 32'(o_s3.fu), 32'(vectors[out_count].fu), out_count);
            compare_field("uop", 32'(o_s3.uop), 32'(vectors[out_count].exp_uop), out_count);
            compare_field("opr_a", o_s3.opr_a, vectors[out_count].exp_a, out_count);
            compare_field("opr_b", o_s3.opr_b, vectors[out_count].exp_b, out_count);
            out_count++;
        end
    end

    always @(posedge g_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout after %0d cycles with %0d of %0d results", cycle_count,
                     out_count, NUM_VEC);
            $display("TEST FAILED");
            $fatal(1, "Timeout");
        end
    end

    // ------------------------------------------------
    // Stimulus loop
    initial begin
        g_resetn   = 1'b0;
        i_flush    = 1'b0;
        i_s2_valid = 1'b0;
        i_s2       = '0;
        fill_vectors();
        repeat (5) @(posedge g_clk);
        g_resetn <= 1'b1;
        for (int i = 0; i < NUM_VEC; i++) begin
            @(posedge g_clk);
            i_s2_valid  <= 1'b1;
            i_s2.rd     <= vectors[i].rd;
            i_s2.fu     <= exec_isa_pkg::fu_e'(vectors[i].fu);
            i_s2.uop    <= vectors[i].uop;
            i_s2.opr_a  <= vectors[i].opr_a;
            i_s2.opr_b  <= vectors[i].opr_b;
            i_s2.opr_c  <= vectors[i].opr_c;
            busy_cycles = 0;
            accepted    = 1'b0;
            while (!accepted) begin
                @(negedge g_clk);
                if (!o_s2_busy) accepted = 1'b1;
                else busy_cycles++;
            end
            // Busy in the presenting cycle plus every step cycle
            if (vectors[i].fu == F_MUL) begin
                assert (busy_cycles >= exec_isa_pkg::MUL_STEPS + 1) else begin
                    $display("Multiply entry %0d was accepted after only %0d busy cycles",
                             i, busy_cycles);
                    $display("TEST FAILED");
                    $fatal(1, "Early accept");
                end
            end
        end
        @(posedge g_clk);
        i_s2_valid <= 1'b0;
        wait (out_count == NUM_VEC);
        repeat (4) @(posedge g_clk);    // Room for a duplicate to show
        $display("TEST OK");
        $finish;
    end

endmodule
